// File: all.f
hdl/spi_cmd_pkg.sv
hdl/cmd_sequencer.sv
hdl/user_regs.sv
hdl/ram_access.sv
hdl/spi_cmd_top.sv
test/spi_cmd_checker.sv
test/spi_cmd_monitor.sv
test/tb_spi_cmd.sv

// File: test/tb_spi_cmd.sv
`timescale 1ns/10ps

module tb_spi_cmd;

    localparam bit little_endian = 1'b1;
    localparam int ram_depth     = 256;
    localparam int ram_addr_w    = 8;
    // about 140 frame bytes at 4 cycles each plus reset and a wide margin
    localparam int max_cycles    = 2000;

    logic                   clk;
    logic                   rst_n;
    spi_cmd_pkg::spi_byte_t Din;
    logic                   transBegin;
    logic                   transEnd;
    spi_cmd_pkg::word_t     sum_in;
    spi_cmd_pkg::spi_byte_t Dout;
    logic                   en;
    spi_cmd_pkg::word_t     num1;
    spi_cmd_pkg::word_t     num2;
    spi_cmd_pkg::word_t     num3;
    logic                   ram_wreq;
    logic [ram_addr_w-1:0]  ram_waddr;
    spi_cmd_pkg::word_t     ram_wdata;
    logic [ram_addr_w-1:0]  ram_raddr;
    spi_cmd_pkg::word_t     ram_rdata;
    spi_cmd_pkg::word_t     ram_mem [0:ram_depth-1];
    logic [31:0]            lcg_state = 32'd58;
    int                     cycle_cnt = 0;
    int                     tests_passed = 0;
    int                     tests_failed = 0;
    string                  test_name;

    spi_cmd_top #(
        .little_endian (little_endian),
        .ram_depth     (ram_depth),
        .ram_addr_w    (ram_addr_w)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .Din        (Din),
        .transBegin (transBegin),
        .transEnd   (transEnd),
        .sum_in     (sum_in),
        .Dout       (Dout),
        .en         (en),
        .num1       (num1),
        .num2       (num2),
        .num3       (num3),
        .ram_wreq   (ram_wreq),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata),
        .ram_raddr  (ram_raddr),
        .ram_rdata  (ram_rdata)
    );

    spi_cmd_monitor #(
        .little_endian (little_endian),
        .ram_depth     (ram_depth),
        .ram_addr_w    (ram_addr_w)
    ) mon (
        .clk        (clk),
        .rst_n      (rst_n),
        .Din        (Din),
        .transBegin (transBegin),
        .transEnd   (transEnd),
        .sum_in     (sum_in),
        .Dout       (Dout),
        .en         (en),
        .num1       (num1),
        .num2       (num2),
        .num3       (num3),
        .ram_wreq   (ram_wreq),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // synchronous-read RAM model
    initial begin
        for (int i = 0; i < ram_depth; i++) begin
            ram_mem[i] = {i[7:0] ^ 8'h3c, ~i[7:0]};
        end
    end

    always @(posedge clk) begin
        if (ram_wreq) begin
            ram_mem[ram_waddr] <= ram_wdata;
        end
        ram_rdata <= ram_mem[ram_raddr];
    end

    function logic [15:0] rand_word();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    task automatic drive_cycle(input logic b, input logic e, input spi_cmd_pkg::spi_byte_t d);
        @(posedge clk);
        #0.5;
        transBegin = b;
        transEnd   = e;
        Din        = d;
    endtask

    // begin, a gap while the byte shifts, end with data, then one idle cycle
    task automatic send_byte(input spi_cmd_pkg::spi_byte_t b);
        drive_cycle(1'b1, 1'b0, 8'h00);
        drive_cycle(1'b0, 1'b0, 8'h00);
        drive_cycle(1'b0, 1'b1, b);
        drive_cycle(1'b0, 1'b0, 8'h00);
    endtask

    task automatic send_word(input spi_cmd_pkg::word_t w);
        if (little_endian) begin
            send_byte(w[7:0]);
            send_byte(w[15:8]);
        end else begin
            send_byte(w[15:8]);
            send_byte(w[7:0]);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic write_reg(input spi_cmd_pkg::spi_byte_t a, input spi_cmd_pkg::word_t w);
        send_byte(spi_cmd_pkg::op_write_reg);
        send_byte(a);
        send_word(w);
    endtask

    task automatic read_reg(input spi_cmd_pkg::spi_byte_t a);
        send_byte(spi_cmd_pkg::op_read_reg);
        send_byte(a);
        send_byte(8'h00);
        send_byte(8'h00);
    endtask

    task automatic write_block(input spi_cmd_pkg::word_t first, input int n);
        send_byte(spi_cmd_pkg::op_write_ram);
        send_word(first);
        send_word(spi_cmd_pkg::word_t'(n));
        for (int i = 0; i < n; i++) begin
            send_word(rand_word());
        end
    endtask

    task automatic read_block(input spi_cmd_pkg::word_t first, input int n);
        send_byte(spi_cmd_pkg::op_read_ram);
        send_word(first);
        send_word(spi_cmd_pkg::word_t'(n));
        for (int i = 0; i < 2 * n; i++) begin
            send_byte(8'h00);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        mon.start_test(name);
    endtask

    task automatic report_test();
        int errs;
        wait_cycles(4);
        #0.5;
        mon.close_test(errs);
        if (errs == 0) begin
            tests_passed++;
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errs);
        end
    endtask

    initial begin
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not complete within %0d cycles", max_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        Din        = '0;
        transBegin = 1'b0;
        transEnd   = 1'b0;
        sum_in     = '0;
        ram_rdata  = '0;
        repeat (16) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        wait_cycles(2);

        begin_test("en_flag");
        read_reg(spi_cmd_pkg::addr_en);
        send_byte(spi_cmd_pkg::op_enable);
        wait_cycles(3);
        mon.check_ports();
        read_reg(spi_cmd_pkg::addr_en);
        send_byte(spi_cmd_pkg::op_disable);
        read_reg(spi_cmd_pkg::addr_en);
        report_test();

        begin_test("num_regs");
        for (int a = 1; a <= 3; a++) begin
            write_reg(8'(a), rand_word());
        end
        wait_cycles(3);
        mon.check_ports();
        for (int a = 1; a <= 3; a++) begin
            read_reg(8'(a));
        end
        report_test();

        begin_test("sum_and_unknown");
        sum_in = rand_word();
        read_reg(spi_cmd_pkg::addr_sum);
        read_reg(8'h09);
        report_test();

        begin_test("ram_block");
        write_block(16'd40, 8);
        read_block(16'd40, 8);
        report_test();

        // crosses the top of the RAM so the last four words are dropped
        begin_test("ram_edge");
        write_block(16'd252, 8);
        read_block(16'd252, 8);
        report_test();

        begin_test("bad_opcode");
        send_byte(8'd4);
        send_byte(8'd5);
        read_reg(spi_cmd_pkg::addr_num2);
        report_test();

        wait_cycles(4);
        $display("tests passed %0d, tests failed %0d, assertion failures %0d",
                 tests_passed, tests_failed, dut.u_seq.u_checker.fail_cnt);
        if (tests_failed == 0 && dut.u_seq.u_checker.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: test/spi_cmd_monitor.sv
`timescale 1ns/10ps

module spi_cmd_monitor #(
    parameter bit little_endian = 1'b1,
    parameter int ram_depth     = 256,
    parameter int ram_addr_w    = 8
) (
    input logic                   clk,
    input logic                   rst_n,
    input spi_cmd_pkg::spi_byte_t Din,
    input logic                   transBegin,
    input logic                   transEnd,
    input spi_cmd_pkg::word_t     sum_in,
    input spi_cmd_pkg::spi_byte_t Dout,
    input logic                   en,
    input spi_cmd_pkg::word_t     num1,
    input spi_cmd_pkg::word_t     num2,
    input spi_cmd_pkg::word_t     num3,
    input logic                   ram_wreq,
    input logic [ram_addr_w-1:0]  ram_waddr,
    input spi_cmd_pkg::word_t     ram_wdata
);

    logic        in_frame;
    logic        reading;
    logic [7:0]  cmd;
    logic [7:0]  reg_sel;
    logic [7:0]  first_b;
    logic [15:0] ptr;
    logic [15:0] words_left;
    int          idx;
    int          rd_pos;
    logic        rd_chk;
    logic [7:0]  rd_exp;
    logic        en_ref;
    logic [15:0] regs_ref [1:3];
    logic [15:0] ram_ref [0:ram_depth-1];
    logic [31:0] wr_q [$];
    int          error_cnt = 0;
    int          test_base = 0;
    string       cur_test = "reset";

    // same fill as the RAM model
    initial begin
        for (int i = 0; i < ram_depth; i++) begin
            ram_ref[i] = {i[7:0] ^ 8'h3c, ~i[7:0]};
        end
    end

    // reference: byte pos of the word a read returns, first on the wire is pos 0
    function automatic logic [7:0] expected_byte(input int pos);
        logic [15:0] w;
        if (cmd == spi_cmd_pkg::op_read_ram) begin
            w = (ptr < ram_depth) ? ram_ref[ptr] : 16'h0000;
        end else if (reg_sel == spi_cmd_pkg::addr_sum) begin
            w = sum_in;
        end else if (reg_sel >= 8'd1 && reg_sel <= 8'd3) begin
            w = regs_ref[reg_sel];
        end else if (reg_sel == spi_cmd_pkg::addr_en) begin
            w = {15'b0, en_ref};
        end else begin
            w = 16'h0000;
        end
        return ((pos == 0) == little_endian) ? w[7:0] : w[15:8];
    endfunction

    task automatic check_value(input string what, input logic [15:0] exp,
                               input logic [15:0] act);
        if (act !== exp) begin
            error_cnt++;
            $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic take_byte(input logic [7:0] b);
        logic [15:0] w;
        w = little_endian ? {b, first_b} : {first_b, b};
        if (idx < 0) begin
            cmd = b;
            idx = 0;
            case (b)
                spi_cmd_pkg::op_disable, spi_cmd_pkg::op_enable: begin
                    en_ref   = (b == spi_cmd_pkg::op_enable);
                    in_frame = 1'b0;
                end
                spi_cmd_pkg::op_write_reg, spi_cmd_pkg::op_read_reg,
                spi_cmd_pkg::op_write_ram, spi_cmd_pkg::op_read_ram: ;
                default: in_frame = 1'b0;
            endcase
        end else if (cmd == spi_cmd_pkg::op_write_reg || cmd == spi_cmd_pkg::op_read_reg) begin
            if (idx == 0) begin
                reg_sel = b;
                reading = (cmd == spi_cmd_pkg::op_read_reg);
                rd_pos  = 0;
            end else if (idx == 2) begin
                if (reg_sel >= 8'd1 && reg_sel <= 8'd3) begin
                    regs_ref[reg_sel] = w;
                end
                in_frame = 1'b0;
            end
            idx++;
        end else begin
            // block: first address, count, then data words
            case (idx)
                1: ptr = w;
                3: begin
                    words_left = w;
                    if (w == 16'h0000) begin
                        in_frame = 1'b0;
                    end else if (cmd == spi_cmd_pkg::op_read_ram) begin
                        reading = 1'b1;
                        rd_pos  = 0;
                    end
                end
                5: begin
                    if (ptr < ram_depth) begin
                        ram_ref[ptr] = w;
                        wr_q.push_back({ptr, w});
                    end
                    ptr++;
                    words_left--;
                    if (words_left == 16'h0000) begin
                        in_frame = 1'b0;
                    end
                end
                default: ;
            endcase
            idx = (idx == 5) ? 4 : idx + 1;
        end
        first_b = b;
    endtask

    // frame decode from port traffic
    always @(posedge clk) begin
        if (!rst_n) begin
            in_frame = 1'b0;
            reading  = 1'b0;
            rd_chk   = 1'b0;
            en_ref   = 1'b0;
            first_b  = 8'h00;
            for (int i = 1; i <= 3; i++) begin
                regs_ref[i] = 16'h0000;
            end
            wr_q.delete();
        end else begin
            rd_chk = 1'b0;
            if (!in_frame) begin
                if (transBegin) begin
                    in_frame = 1'b1;
                    reading  = 1'b0;
                    idx      = -1;
                end
            end else if (reading) begin
                if (transBegin) begin
                    rd_exp = expected_byte(rd_pos);
                    rd_chk = 1'b1;
                end
                if (transEnd) begin
                    rd_pos++;
                    if (rd_pos == 2) begin
                        rd_pos = 0;
                        if (cmd == spi_cmd_pkg::op_read_ram && words_left != 16'd1) begin
                            ptr++;
                            words_left--;
                        end else begin
                            in_frame = 1'b0;
                            reading  = 1'b0;
                        end
                    end
                end
            end else if (transEnd) begin
                take_byte(Din);
            end
        end
    end

    // compare mid-cycle where outputs are settled
    always @(negedge clk) begin
        logic [31:0] exp_wr;
        if (rst_n && rd_chk) begin
            check_value("Dout", {8'h00, rd_exp}, {8'h00, Dout});
        end
        if (rst_n && ram_wreq) begin
            if (wr_q.size() == 0) begin
                error_cnt++;
                $display("%s: RAM write request at address %0d with no write pending",
                         cur_test, ram_waddr);
            end else begin
                exp_wr = wr_q.pop_front();
                check_value("ram_waddr", exp_wr[31:16], spi_cmd_pkg::word_t'(ram_waddr));
                check_value("ram_wdata", exp_wr[15:0], ram_wdata);
            end
        end
    end

    task automatic start_test(input string name);
        cur_test  = name;
        test_base = error_cnt;
    endtask

    task automatic check_ports();
        check_value("en", {15'b0, en_ref}, {15'b0, en});
        check_value("num1", regs_ref[1], num1);
        check_value("num2", regs_ref[2], num2);
        check_value("num3", regs_ref[3], num3);
    endtask

    task automatic close_test(output int errs);
        check_ports();
        if (wr_q.size() != 0) begin
            error_cnt++;
            $display("%s: %0d RAM writes were expected but never requested",
                     cur_test, wr_q.size());
        end
        for (int i = 0; i < ram_depth; i++) begin
            check_value($sformatf("ram_mem[%0d]", i), ram_ref[i], tb_spi_cmd.ram_mem[i]);
        end
        errs = error_cnt - test_base;
    endtask

endmodule

// File: test/spi_cmd_checker.sv
`timescale 1ns/10ps

module spi_cmd_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   transBegin,
    input spi_cmd_pkg::spi_byte_t Dout,
    input logic                   ram_wr,
    input logic                   en_set,
    input logic                   en_clr
);

    int fail_cnt = 0;

    // a read byte only shows in the cycle after transBegin
    dout_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (Dout != '0) |-> $past(transBegin))
        else begin
            fail_cnt++;
            $error("Dout is nonzero outside a read byte cycle");
        end

    wr_single: assert property (@(posedge clk) disable iff (!rst_n)
        ram_wr |=> !ram_wr)
        else begin
            fail_cnt++;
            $error("RAM write strobe lasted two cycles");
        end

    en_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(en_set && en_clr))
        else begin
            fail_cnt++;
            $error("en_set and en_clr high together");
        end

endmodule

bind cmd_sequencer spi_cmd_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .transBegin (transBegin),
    .Dout       (Dout),
    .ram_wr     (ram_wr),
    .en_set     (en_set),
    .en_clr     (en_clr)
);

// File: hdl/spi_cmd_top.sv
`timescale 1ns/10ps

module spi_cmd_top #(
    parameter bit little_endian = 1'b1,
    parameter int ram_depth     = 256,
    parameter int ram_addr_w    = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  spi_cmd_pkg::spi_byte_t Din,
    input  logic                   transBegin,
    input  logic                   transEnd,
    input  spi_cmd_pkg::word_t     sum_in,
    output spi_cmd_pkg::spi_byte_t Dout,
    output logic                   en,
    output spi_cmd_pkg::word_t     num1,
    output spi_cmd_pkg::word_t     num2,
    output spi_cmd_pkg::word_t     num3,
    output logic                   ram_wreq,
    output logic [ram_addr_w-1:0]  ram_waddr,
    output spi_cmd_pkg::word_t     ram_wdata,
    output logic [ram_addr_w-1:0]  ram_raddr,
    input  spi_cmd_pkg::word_t     ram_rdata
);

    logic                   en_set;
    logic                   en_clr;
    logic                   reg_wr;
    spi_cmd_pkg::spi_byte_t reg_addr;
    spi_cmd_pkg::word_t     wr_word;
    spi_cmd_pkg::word_t     rd_word;
    logic                   ram_addr_load;
    logic                   ram_rd_addr_set;
    logic                   ram_wr;
    logic                   ram_step;
    spi_cmd_pkg::word_t     ram_start_addr;
    spi_cmd_pkg::word_t     ram_word;

    cmd_sequencer #(
        .little_endian (little_endian)
    ) u_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .Din             (Din),
        .transBegin      (transBegin),
        .transEnd        (transEnd),
        .rd_word         (rd_word),
        .ram_word        (ram_word),
        .Dout            (Dout),
        .en_set          (en_set),
        .en_clr          (en_clr),
        .reg_wr          (reg_wr),
        .reg_addr        (reg_addr),
        .wr_word         (wr_word),
        .ram_addr_load   (ram_addr_load),
        .ram_rd_addr_set (ram_rd_addr_set),
        .ram_wr          (ram_wr),
        .ram_step        (ram_step),
        .ram_start_addr  (ram_start_addr)
    );

    user_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_set   (en_set),
        .en_clr   (en_clr),
        .reg_wr   (reg_wr),
        .reg_addr (reg_addr),
        .wr_word  (wr_word),
        .sum_in   (sum_in),
        .rd_word  (rd_word),
        .en       (en),
        .num1     (num1),
        .num2     (num2),
        .num3     (num3)
    );

    ram_access #(
        .ram_depth  (ram_depth),
        .ram_addr_w (ram_addr_w)
    ) u_ram (
        .clk             (clk),
        .rst_n           (rst_n),
        .ram_addr_load   (ram_addr_load),
        .ram_start_addr  (ram_start_addr),
        .ram_step        (ram_step),
        .ram_wr          (ram_wr),
        .ram_rd_addr_set (ram_rd_addr_set),
        .wr_word         (wr_word),
        .ram_rdata       (ram_rdata),
        .ram_word        (ram_word),
        .ram_wreq        (ram_wreq),
        .ram_waddr       (ram_waddr),
        .ram_wdata       (ram_wdata),
        .ram_raddr       (ram_raddr)
    );

endmodule

// File: hdl/ram_access.sv
`timescale 1ns/10ps

module ram_access #(
    parameter int ram_depth  = 256,
    parameter int ram_addr_w = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ram_addr_load,
    input  spi_cmd_pkg::word_t    ram_start_addr,
    input  logic                  ram_step,
    input  logic                  ram_wr,
    input  logic                  ram_rd_addr_set,
    input  spi_cmd_pkg::word_t    wr_word,
    input  spi_cmd_pkg::word_t    ram_rdata,
    output spi_cmd_pkg::word_t    ram_word,
    output logic                  ram_wreq,
    output logic [ram_addr_w-1:0] ram_waddr,
    output spi_cmd_pkg::word_t    ram_wdata,
    output logic [ram_addr_w-1:0] ram_raddr
);

    spi_cmd_pkg::word_t addr;
    spi_cmd_pkg::word_t addr_nxt;
    logic               in_range;

    // running word address of the current block
    assign addr_nxt = ram_addr_load ? ram_start_addr :
                      ram_step      ? addr + 16'd1   : addr;
    assign in_range = (addr < spi_cmd_pkg::word_t'(ram_depth));
    assign ram_word = in_range ? ram_rdata : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr      <= '0;
            ram_raddr <= '0;
            ram_wreq  <= 1'b0;
            ram_waddr <= '0;
            ram_wdata <= '0;
        end else begin
            addr     <= addr_nxt;
            ram_wreq <= ram_wr && in_range;
            // read address leads so data is ready before the next byte
            if (ram_rd_addr_set) begin
                ram_raddr <= addr_nxt[ram_addr_w-1:0];
            end
            if (ram_wr) begin
                ram_waddr <= addr[ram_addr_w-1:0];
                ram_wdata <= wr_word;
            end
        end
    end

endmodule

// File: hdl/user_regs.sv
`timescale 1ns/10ps

module user_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en_set,
    input  logic                   en_clr,
    input  logic                   reg_wr,
    input  spi_cmd_pkg::spi_byte_t reg_addr,
    input  spi_cmd_pkg::word_t     wr_word,
    input  spi_cmd_pkg::word_t     sum_in,
    output spi_cmd_pkg::word_t     rd_word,
    output logic                   en,
    output spi_cmd_pkg::word_t     num1,
    output spi_cmd_pkg::word_t     num2,
    output spi_cmd_pkg::word_t     num3
);

    localparam int bw = spi_cmd_pkg::byte_w;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en   <= 1'b0;
            num1 <= '0;
            num2 <= '0;
            num3 <= '0;
        end else begin
            if (en_set) begin
                en <= 1'b1;
            end else if (en_clr) begin
                en <= 1'b0;
            end
            // sum and en are not writable here
            if (reg_wr) begin
                case (spi_cmd_pkg::reg_addr_e'(reg_addr))
                    spi_cmd_pkg::addr_num1: num1 <= wr_word;
                    spi_cmd_pkg::addr_num2: num2 <= wr_word;
                    spi_cmd_pkg::addr_num3: num3 <= wr_word;
                    default: ;
                endcase
            end
        end
    end

    // readback follows reg_addr one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_word <= '0;
        end else begin
            case (spi_cmd_pkg::reg_addr_e'(reg_addr))
                spi_cmd_pkg::addr_sum:  rd_word <= sum_in;
                spi_cmd_pkg::addr_num1: rd_word <= num1;
                spi_cmd_pkg::addr_num2: rd_word <= num2;
                spi_cmd_pkg::addr_num3: rd_word <= num3;
                spi_cmd_pkg::addr_en:   rd_word <= {{(2*bw-1){1'b0}}, en};
                default:                rd_word <= '0;
            endcase
        end
    end

endmodule

// File: hdl/cmd_sequencer.sv
`timescale 1ns/10ps

module cmd_sequencer #(
    parameter bit little_endian = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  spi_cmd_pkg::spi_byte_t Din,
    input  logic                   transBegin,
    input  logic                   transEnd,
    input  spi_cmd_pkg::word_t     rd_word,
    input  spi_cmd_pkg::word_t     ram_word,
    output spi_cmd_pkg::spi_byte_t Dout,
    output logic                   en_set,
    output logic                   en_clr,
    output logic                   reg_wr,
    output spi_cmd_pkg::spi_byte_t reg_addr,
    output spi_cmd_pkg::word_t     wr_word,
    output logic                   ram_addr_load,
    output logic                   ram_rd_addr_set,
    output logic                   ram_wr,
    output logic                   ram_step,
    output spi_cmd_pkg::word_t     ram_start_addr
);

    localparam int bw = spi_cmd_pkg::byte_w;

    // one byte-wait state serves every header and write-data byte
    typedef enum logic [2:0] {
        s_idle,
        s_opcode,
        s_byte,
        s_exec,
        s_rd_wait,
        s_rd_byte,
        s_rd_end
    } state_e;

    state_e               state;
    state_e               state_nxt;
    spi_cmd_pkg::opcode_e op;
    logic [2:0]           byte_cnt;
    logic                 rd_idx;
    spi_cmd_pkg::word_t   word_cnt;
    spi_cmd_pkg::word_t   cnt_nxt;
    spi_cmd_pkg::word_t   rd_src;
    logic                 second;
    logic                 hi_pos;
    logic                 out_hi;
    logic                 en_set_d;
    logic                 en_clr_d;
    logic                 reg_wr_d;
    logic                 ram_wr_d;
    logic                 ram_step_d;
    logic                 ram_load_d;
    logic                 ram_rd_set_d;

    function automatic spi_cmd_pkg::word_t put_byte(spi_cmd_pkg::word_t base, logic hi,
                                                    spi_cmd_pkg::spi_byte_t b);
        if (hi) begin
            return {b, base[bw-1:0]};
        end
        return {base[2*bw-1:bw], b};
    endfunction

    // register data starts at byte 1, RAM fields at even bytes
    assign second  = (op == spi_cmd_pkg::op_write_reg) ? (byte_cnt == 3'd2) : byte_cnt[0];
    assign hi_pos  = (second == little_endian);
    assign cnt_nxt = put_byte(word_cnt, hi_pos, Din);

    always_comb begin
        state_nxt    = state;
        en_set_d     = 1'b0;
        en_clr_d     = 1'b0;
        reg_wr_d     = 1'b0;
        ram_wr_d     = 1'b0;
        ram_step_d   = 1'b0;
        ram_load_d   = 1'b0;
        ram_rd_set_d = 1'b0;
        case (state)
            s_idle: begin
                if (transBegin) begin
                    state_nxt = s_opcode;
                end
            end
            s_opcode: begin
                if (transEnd) begin
                    case (spi_cmd_pkg::opcode_e'(Din))
                        spi_cmd_pkg::op_disable,
                        spi_cmd_pkg::op_enable:    state_nxt = s_exec;
                        spi_cmd_pkg::op_write_reg,
                        spi_cmd_pkg::op_read_reg,
                        spi_cmd_pkg::op_write_ram,
                        spi_cmd_pkg::op_read_ram:  state_nxt = s_byte;
                        default:                   state_nxt = s_idle;
                    endcase
                end
            end
            s_byte: begin
                if (transEnd) begin
                    case (op)
                        spi_cmd_pkg::op_read_reg: state_nxt = s_rd_wait;
                        spi_cmd_pkg::op_write_reg: begin
                            if (byte_cnt == 3'd2) begin
                                state_nxt = s_exec;
                            end
                        end
                        default: begin
                            // block commands: addr 0-1, count 2-3, data 4-5
                            if (byte_cnt == 3'd1) begin
                                ram_load_d = 1'b1;
                            end
                            if (byte_cnt == 3'd3) begin
                                if (cnt_nxt == '0) begin
                                    state_nxt = s_idle;
                                end else if (op == spi_cmd_pkg::op_read_ram) begin
                                    state_nxt    = s_rd_wait;
                                    ram_rd_set_d = 1'b1;
                                end
                            end
                            if (byte_cnt == 3'd5) begin
                                state_nxt = s_exec;
                            end
                        end
                    endcase
                end
            end
            s_exec: begin
                state_nxt = s_idle;
                case (op)
                    spi_cmd_pkg::op_disable:   en_clr_d = 1'b1;
                    spi_cmd_pkg::op_enable:    en_set_d = 1'b1;
                    spi_cmd_pkg::op_write_reg: reg_wr_d = 1'b1;
                    spi_cmd_pkg::op_write_ram: begin
                        ram_wr_d   = 1'b1;
                        ram_step_d = 1'b1;
                        if (word_cnt != 16'd1) begin
                            state_nxt = s_byte;
                        end
                    end
                    default: ;
                endcase
            end
            s_rd_wait: begin
                if (transBegin) begin
                    state_nxt = s_rd_byte;
                end
            end
            s_rd_byte: state_nxt = rd_idx ? s_rd_end : s_rd_wait;
            s_rd_end: begin
                if (transEnd) begin
                    state_nxt = s_idle;
                    // next word address goes out with the step
                    if (op == spi_cmd_pkg::op_read_ram && word_cnt != 16'd1) begin
                        state_nxt    = s_rd_wait;
                        ram_step_d   = 1'b1;
                        ram_rd_set_d = 1'b1;
                    end
                end
            end
            default: state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= s_idle;
            en_set          <= 1'b0;
            en_clr          <= 1'b0;
            reg_wr          <= 1'b0;
            ram_wr          <= 1'b0;
            ram_step        <= 1'b0;
            ram_addr_load   <= 1'b0;
            ram_rd_addr_set <= 1'b0;
        end else begin
            state           <= state_nxt;
            en_set          <= en_set_d;
            en_clr          <= en_clr_d;
            reg_wr          <= reg_wr_d;
            ram_wr          <= ram_wr_d;
            ram_step        <= ram_step_d;
            ram_addr_load   <= ram_load_d;
            ram_rd_addr_set <= ram_rd_set_d;
        end
    end

    // field assembly and counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op             <= spi_cmd_pkg::op_disable;
            byte_cnt       <= '0;
            rd_idx         <= 1'b0;
            word_cnt       <= '0;
            reg_addr       <= '0;
            wr_word        <= '0;
            ram_start_addr <= '0;
        end else begin
            if (state == s_opcode && transEnd) begin
                op       <= spi_cmd_pkg::opcode_e'(Din);
                byte_cnt <= '0;
                rd_idx   <= 1'b0;
            end
            if (state == s_byte && transEnd) begin
                byte_cnt <= byte_cnt + 3'd1;
                if (op == spi_cmd_pkg::op_read_reg || op == spi_cmd_pkg::op_write_reg) begin
                    if (byte_cnt == 3'd0) begin
                        reg_addr <= Din;
                    end else if (!second) begin
                        wr_word <= put_byte('0, hi_pos, Din);
                    end else begin
                        wr_word <= put_byte(wr_word, hi_pos, Din);
                    end
                end else begin
                    case (byte_cnt)
                        3'd0:    ram_start_addr <= put_byte('0, hi_pos, Din);
                        3'd1:    ram_start_addr <= put_byte(ram_start_addr, hi_pos, Din);
                        3'd2:    word_cnt <= put_byte('0, hi_pos, Din);
                        3'd3:    word_cnt <= cnt_nxt;
                        3'd4:    wr_word <= put_byte('0, hi_pos, Din);
                        default: wr_word <= put_byte(wr_word, hi_pos, Din);
                    endcase
                end
            end
            // back to the first data byte of the next word
            if (state == s_exec) begin
                byte_cnt <= 3'd4;
            end
            if (ram_step_d) begin
                word_cnt <= word_cnt - 16'd1;
            end
            if (state == s_rd_byte) begin
                rd_idx <= ~rd_idx;
            end
        end
    end

    // read byte select
    assign rd_src = (op == spi_cmd_pkg::op_read_ram) ? ram_word : rd_word;
    assign out_hi = (rd_idx == little_endian);
    assign Dout   = (state != s_rd_byte) ? '0 :
                    out_hi               ? rd_src[2*bw-1:bw] : rd_src[bw-1:0];

endmodule

// File: hdl/spi_cmd_pkg.sv
package spi_cmd_pkg;

    // width of one serial transfer
    parameter int byte_w = 8;

    typedef logic [byte_w-1:0]   spi_byte_t;

    // register/RAM data word, also first address and word count
    typedef logic [2*byte_w-1:0] word_t;

    // command opcodes, 4 and 5 are unused
    typedef enum logic [7:0] {
        op_disable   = 8'd0,
        op_enable    = 8'd1,
        op_write_reg = 8'd2,
        op_read_reg  = 8'd3,
        op_write_ram = 8'd6,
        op_read_ram  = 8'd7
    } opcode_e;

    // user register map
    typedef enum logic [7:0] {
        addr_sum  = 8'd0,
        addr_num1 = 8'd1,
        addr_num2 = 8'd2,
        addr_num3 = 8'd3,
        addr_en   = 8'd4
    } reg_addr_e;

endpackage
